//--- source/cpu_pkg.sv
package cpu_pkg;

    localparam int data_width     = 32;
    localparam int addr_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int alu_op_width   = 4;

    ////////////////////////////////////////
    // opcodes and functs
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    localparam logic [alu_op_width-1:0] alu_add = 4'd0;
    localparam logic [alu_op_width-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_width-1:0] alu_and = 4'd2;
    localparam logic [alu_op_width-1:0] alu_or  = 4'd3;
    localparam logic [alu_op_width-1:0] alu_slt = 4'd4;
    localparam logic [alu_op_width-1:0] alu_lui = 4'd5;  // imm into upper half

    // operand source in execute
    localparam logic [1:0] fwd_reg = 2'd0;
    localparam logic [1:0] fwd_mem = 2'd1;
    localparam logic [1:0] fwd_wb  = 2'd2;

    ////////////////////////////////////////
    // instruction word in three views
    typedef union packed {
        struct packed {
            logic [5:0]                opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [reg_addr_width-1:0] rd;
            logic [4:0]                shamt;
            logic [5:0]                funct;
        } r;
        struct packed {
            logic [5:0]                opcode;
            logic [reg_addr_width-1:0] rs;
            logic [reg_addr_width-1:0] rt;
            logic [15:0]               imm;
        } i;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j;
    } instr_t;

    ////////////////////////////////////////
    // stage registers where all-zero is a bubble
    typedef struct packed {
        instr_t                instr;
        logic [addr_width-1:0] pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic [addr_width-1:0]     pc_plus4;
        logic [data_width-1:0]     rs_val;
        logic [data_width-1:0]     rt_val;
        logic [data_width-1:0]     imm;
        logic [reg_addr_width-1:0] rs;
        logic [reg_addr_width-1:0] rt;
        logic [reg_addr_width-1:0] dest;
        logic [alu_op_width-1:0]   alu_op;
        logic                      use_imm;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
        logic                      branch;
        logic                      jump;
        logic [addr_width-1:0]     jump_target;
    } id_ex_t;

    typedef struct packed {
        logic [data_width-1:0]     alu_result;
        logic [data_width-1:0]     store_data;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
        logic                      mem_read;
        logic                      mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic [data_width-1:0]     wb_data;
        logic [reg_addr_width-1:0] dest;
        logic                      reg_write;
    } mem_wb_t;

endpackage

//--- source/register_file.sv
module register_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_addr,
    output logic [cpu_pkg::data_width-1:0]     rs_data,
    output logic [cpu_pkg::data_width-1:0]     rt_data,
    input  logic                               we,
    input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [cpu_pkg::data_width-1:0]     wr_data
);
    import cpu_pkg::*;

    logic [data_width-1:0] regs [0:(1 << reg_addr_width) - 1];

    function automatic logic [data_width-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        if (addr == '0)
            return '0;
        if (we && wr_addr == addr)
            return wr_data;   // same-cycle write shows through
        return regs[addr];
    endfunction

    always_comb
    begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int k = 0; k < (1 << reg_addr_width); k++)
                regs[k] <= '0;
        end
        else if (we && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

endmodule

//--- source/fetch_stage.sv
module fetch_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic                           flush,
    input  logic                           take_branch,
    input  logic [cpu_pkg::addr_width-1:0] branch_target,
    output logic [cpu_pkg::addr_width-1:0] imem_addr,
    input  cpu_pkg::instr_t                imem_data,
    output cpu_pkg::if_id_t                if_id
);
    import cpu_pkg::*;

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] pc_plus4;

    assign pc_plus4  = pc + 32'd4;
    assign imem_addr = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (take_branch)   // redirect wins over a stall
            pc <= branch_target;
        else if (!stall)
            pc <= pc_plus4;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            if_id <= '0;
        else if (!stall)
        begin
            if_id.instr    <= imem_data;
            if_id.pc_plus4 <= pc_plus4;
        end
    end

endmodule

//--- source/decode_stage.sv
module decode_stage (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall,
    input  logic                               flush,
    input  cpu_pkg::if_id_t                    if_id,
    input  cpu_pkg::mem_wb_t                   mem_wb,
    output cpu_pkg::id_ex_t                    id_ex,
    output logic [cpu_pkg::reg_addr_width-1:0] dec_rs,
    output logic [cpu_pkg::reg_addr_width-1:0] dec_rt
);
    import cpu_pkg::*;

    instr_t                instr;
    id_ex_t                dec;
    logic [data_width-1:0] rs_data;
    logic [data_width-1:0] rt_data;
    logic                  reads_rt;

    assign instr = if_id.instr;

    register_file i_register_file (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (instr.r.rs),
        .rt_addr (instr.r.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .we      (mem_wb.reg_write),
        .wr_addr (mem_wb.dest),
        .wr_data (mem_wb.wb_data)
    );

    always_comb
    begin
        dec             = '0;
        reads_rt        = 1'b0;
        dec.pc_plus4    = if_id.pc_plus4;
        dec.rs_val      = rs_data;
        dec.rt_val      = rt_data;
        dec.rs          = instr.i.rs;
        dec.rt          = instr.i.rt;
        dec.dest        = instr.i.rt;   // i-type default
        dec.alu_op      = alu_add;
        dec.use_imm     = 1'b1;
        dec.imm         = {{16{instr.i.imm[15]}}, instr.i.imm};
        dec.jump_target = {if_id.pc_plus4[31:28], instr.j.target, 2'b00};

        case (instr.r.opcode)
            op_rtype:
            begin
                reads_rt      = 1'b1;
                dec.use_imm   = 1'b0;
                dec.dest      = instr.r.rd;
                dec.reg_write = 1'b1;
                case (instr.r.funct)
                    fn_add:  dec.alu_op = alu_add;
                    fn_sub:  dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.reg_write = 1'b0;   // nop and unknowns
                endcase
            end
            op_addi: dec.reg_write = 1'b1;
            op_andi:
            begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_and;
            end
            op_ori:
            begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_or;
            end
            op_lui:
            begin
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_lui;
            end
            op_lw:
            begin
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            op_sw:
            begin
                reads_rt      = 1'b1;
                dec.mem_write = 1'b1;
            end
            op_beq:
            begin
                reads_rt    = 1'b1;
                dec.use_imm = 1'b0;
                dec.branch  = 1'b1;
            end
            op_j:    dec.jump = 1'b1;
            default: ;
        endcase

        // logic immediates are zero extended
        if (instr.i.opcode inside {op_andi, op_ori, op_lui})
            dec.imm = {16'b0, instr.i.imm};
    end

    // only real source registers go to the hazard check
    assign dec_rs = dec.jump ? '0 : instr.i.rs;
    assign dec_rt = reads_rt ? instr.i.rt : '0;

    always_ff @(posedge clk)
    begin
        if (rst || stall || flush)
            id_ex <= '0;   // bubble
        else
            id_ex <= dec;
    end

endmodule

//--- source/execute_stage.sv
module execute_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  cpu_pkg::id_ex_t                id_ex,
    input  cpu_pkg::mem_wb_t               mem_wb,
    input  logic [1:0]                     fwd_a,
    input  logic [1:0]                     fwd_b,
    output cpu_pkg::ex_mem_t               ex_mem,
    output logic                           take_branch,
    output logic [cpu_pkg::addr_width-1:0] branch_target
);
    import cpu_pkg::*;

    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] alu_b;
    logic [data_width-1:0] alu_y;
    ex_mem_t               ex_next;

    function automatic logic [data_width-1:0] fwd_mux(input logic [1:0] sel,
                                                      input logic [data_width-1:0] reg_val);
        case (sel)
            fwd_mem: return ex_mem.alu_result;
            fwd_wb:  return mem_wb.wb_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb
    begin
        op_a = fwd_mux(fwd_a, id_ex.rs_val);
        op_b = fwd_mux(fwd_b, id_ex.rt_val);
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    ////////////////////////////////////////
    // alu
    always_comb
    begin
        case (id_ex.alu_op)
            alu_add: alu_y = op_a + alu_b;
            alu_sub: alu_y = op_a - alu_b;
            alu_and: alu_y = op_a & alu_b;
            alu_or:  alu_y = op_a | alu_b;
            alu_slt: alu_y = {{(data_width - 1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            alu_lui: alu_y = {alu_b[15:0], 16'b0};
            default: alu_y = '0;
        endcase
    end

    // beq compares the two forwarded registers
    assign take_branch   = id_ex.jump || (id_ex.branch && op_a == op_b);
    assign branch_target = id_ex.jump ? id_ex.jump_target
                         : id_ex.pc_plus4 + {id_ex.imm[addr_width-3:0], 2'b00};

    always_comb
    begin
        ex_next.alu_result = alu_y;
        ex_next.store_data = op_b;
        ex_next.dest       = id_ex.dest;
        ex_next.reg_write  = id_ex.reg_write;
        ex_next.mem_read   = id_ex.mem_read;
        ex_next.mem_write  = id_ex.mem_write;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            ex_mem <= '0;
        else
            ex_mem <= ex_next;
    end

endmodule

//--- source/memory_stage.sv
module memory_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  cpu_pkg::ex_mem_t               ex_mem,
    output logic [cpu_pkg::addr_width-1:0] dmem_addr,
    output logic [cpu_pkg::data_width-1:0] dmem_wdata,
    output logic                           dmem_we,
    output logic                           dmem_re,
    input  logic [cpu_pkg::data_width-1:0] dmem_rdata,
    output cpu_pkg::mem_wb_t               mem_wb
);
    import cpu_pkg::*;

    mem_wb_t wb_next;

    // data memory answers in the same cycle
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_write;
    assign dmem_re    = ex_mem.mem_read;

    always_comb
    begin
        wb_next.wb_data   = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;
        wb_next.dest      = ex_mem.dest;
        wb_next.reg_write = ex_mem.reg_write;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            mem_wb <= '0;
        else
            mem_wb <= wb_next;
    end

endmodule

//--- source/hazard_unit.sv
module hazard_unit (
    input  logic [cpu_pkg::reg_addr_width-1:0] dec_rs,
    input  logic [cpu_pkg::reg_addr_width-1:0] dec_rt,
    input  cpu_pkg::id_ex_t                    id_ex,
    input  cpu_pkg::ex_mem_t                   ex_mem,
    input  cpu_pkg::mem_wb_t                   mem_wb,
    input  logic                               take_branch,
    output logic                               stall,
    output logic                               flush,
    output logic [1:0]                         fwd_a,
    output logic [1:0]                         fwd_b
);
    import cpu_pkg::*;

    logic load_use;

    // newest producer first and r0 never forwards
    function automatic logic [1:0] pick_fwd(input logic [reg_addr_width-1:0] src);
        if (src == '0)
            return fwd_reg;
        if (ex_mem.reg_write && ex_mem.dest == src)
            return fwd_mem;
        if (mem_wb.reg_write && mem_wb.dest == src)
            return fwd_wb;
        return fwd_reg;
    endfunction

    ////////////////////////////////////////
    // load in execute and consumer in decode
    always_comb
    begin
        load_use = id_ex.mem_read && id_ex.dest != '0
                && (id_ex.dest == dec_rs || id_ex.dest == dec_rt);
    end

    assign stall = load_use;
    assign flush = take_branch;   // kills fetch and decode

    always_comb
    begin
        fwd_a = pick_fwd(id_ex.rs);
        fwd_b = pick_fwd(id_ex.rt);
    end

endmodule

//--- source/mips_cpu.sv
module mips_cpu (
    input  logic                           clk,
    input  logic                           rst,
    output logic [cpu_pkg::addr_width-1:0] imem_addr,
    input  cpu_pkg::instr_t                imem_data,
    output logic [cpu_pkg::addr_width-1:0] dmem_addr,
    output logic [cpu_pkg::data_width-1:0] dmem_wdata,
    output logic                           dmem_we,
    output logic                           dmem_re,
    input  logic [cpu_pkg::data_width-1:0] dmem_rdata
);
    import cpu_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    logic                      stall;
    logic                      flush;
    logic                      take_branch;
    logic [addr_width-1:0]     branch_target;
    logic [1:0]                fwd_a;
    logic [1:0]                fwd_b;
    logic [reg_addr_width-1:0] dec_rs;
    logic [reg_addr_width-1:0] dec_rt;

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_id         (if_id)
    );

    decode_stage i_decode_stage (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .if_id  (if_id),
        .mem_wb (mem_wb),   // register file write port
        .id_ex  (id_ex),
        .dec_rs (dec_rs),
        .dec_rt (dec_rt)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .id_ex         (id_ex),
        .mem_wb        (mem_wb),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .ex_mem        (ex_mem),
        .take_branch   (take_branch),
        .branch_target (branch_target)
    );

    memory_stage i_memory_stage (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .mem_wb     (mem_wb)
    );

    ////////////////////////////////////////
    // stalls, flushes and forwarding
    hazard_unit i_hazard_unit (
        .dec_rs      (dec_rs),
        .dec_rt      (dec_rt),
        .id_ex       (id_ex),
        .ex_mem      (ex_mem),
        .mem_wb      (mem_wb),
        .take_branch (take_branch),
        .stall       (stall),
        .flush       (flush),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b)
    );

endmodule

//--- verif/mips_cpu_checker.sv
module mips_cpu_checker (
    input logic                           clk,
    input logic                           rst,
    input logic [cpu_pkg::addr_width-1:0] imem_addr,
    input logic                           dmem_we,
    input logic                           dmem_re
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    a_we_re_exclusive: assert property (@(posedge clk) disable iff (rst) !(dmem_we && dmem_re))
    else
    begin
        fail_count++;
        $error("dmem_we and dmem_re high in the same cycle");
    end

    // strobes quiet once reset has cleared the pipeline
    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !dmem_we && !dmem_re)
    else
    begin
        fail_count++;
        $error("memory strobe high in the cycle after reset");
    end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else
    begin
        fail_count++;
        $error("imem_addr not word aligned");
    end

endmodule

bind mips_cpu mips_cpu_checker i_mips_cpu_checker (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re)
);

//--- verif/tb_mips_cpu.sv
module tb_mips_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    localparam int    clk_period  = 100;
    localparam int    drive_delay = 5;
    localparam int    imem_words  = 256;
    localparam int    dmem_words  = 256;
    localparam int    max_records = 1024;
    localparam int    tail_cycles = 20;
    localparam int    wd_scale    = 4;
    localparam string input_file  = "verif/program_input.txt";

    logic                  clk;
    logic                  rst;
    logic [addr_width-1:0] imem_addr;
    instr_t                imem_data;
    logic [addr_width-1:0] dmem_addr;
    logic [data_width-1:0] dmem_wdata;
    logic                  dmem_we;
    logic                  dmem_re;
    logic [data_width-1:0] dmem_rdata;

    logic [data_width-1:0] imem [0:imem_words-1];
    logic [data_width-1:0] dmem [0:dmem_words-1];
    logic [addr_width-1:0] exp_addr [$];
    logic [data_width-1:0] exp_data [$];
    int                    prog_words;
    int                    record_total;
    int                    store_count;
    bit                    loaded;

    // store seen mid-cycle and written after the next rising edge
    logic                  wr_pending;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;

    mips_cpu i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////
    // memory models
    always_comb
    begin
        if (imem_addr[addr_width-1:2] < prog_words)
            imem_data = imem[imem_addr[9:2]];
        else
            imem_data = '0;   // nop past the program
    end

    // read data only while a load strobes
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 'x;

    always @(posedge clk)
    begin
        #drive_delay;
        if (wr_pending)
        begin
            dmem[wr_addr[9:2]] = wr_data;
            wr_pending = 1'b0;
        end
    end

    ////////////////////////////////////////
    // failure and compare
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                              input logic [addr_width-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] at %0d ns: %s expected %h, got %h",
                               $time, name, exp, got));
    endtask

    task automatic check_data(input string name, input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("[ERROR] at %0d ns: %s expected %h, got %h",
                               $time, name, exp, got));
    endtask

    function automatic bit dmem_addr_ok(input logic [addr_width-1:0] addr);
        return addr[1:0] == 2'b00 && addr < dmem_words * 4;
    endfunction

    ////////////////////////////////////////
    // input file
    task automatic fetch_line(input int fd, output string line);
        string raw;
        string tok;
        bit    found;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd))
        begin
            raw = "";
            if ($fgets(raw, fd) > 0 && $sscanf(raw, "%s", tok) == 1)
                found = !(tok.len() >= 2 && tok.substr(0, 1) == "//");   // skip comments
            if (found)
                line = raw;
        end
        if (!found)
            fail_run("the input file ended before all its entries were read");
    endtask

    task automatic read_count(input int fd, input int limit, output int count);
        string line;
        fetch_line(fd, line);
        if ($sscanf(line, "%d", count) != 1 || count < 1 || count > limit)
            fail_run("the input file has a bad count line");
    endtask

    task automatic load_input();
        int                    fd;
        int                    k;
        string                 line;
        logic [data_width-1:0] word;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        fd = $fopen(input_file, "r");
        if (fd == 0)
            fail_run("could not open verif/program_input.txt");
        else
        begin
            read_count(fd, imem_words, prog_words);
            for (k = 0; k < prog_words; k++)
            begin
                fetch_line(fd, line);
                if ($sscanf(line, "%h", word) != 1)
                    fail_run("the input file has a bad program word");
                else
                    imem[k] = word;
            end
            read_count(fd, max_records, record_total);
            for (k = 0; k < record_total; k++)
            begin
                fetch_line(fd, line);
                if ($sscanf(line, "%h %h", addr, data) != 2)
                    fail_run("the input file has a bad store record");
                else
                begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(data);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic fill_dmem();
        int k;
        for (k = 0; k < dmem_words; k++)
            dmem[k] = 32'hd0d0_0000 | k;   // distinct word per address
    endtask

    ////////////////////////////////////////
    // store monitor at the falling edge
    task automatic take_store();
        if (!dmem_addr_ok(dmem_addr))
            fail_run("a store went outside the data memory model");
        else if (exp_addr.size() == 0)
            fail_run("a store appeared after the last expected record");
        else
        begin
            check_addr("dmem_addr", dmem_addr, exp_addr.pop_front());
            check_data("dmem_wdata", dmem_wdata, exp_data.pop_front());
            wr_pending = 1'b1;
            wr_addr    = dmem_addr;
            wr_data    = dmem_wdata;
            store_count++;
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst && dmem_we === 1'b1)
            take_store();
        else if (!rst && dmem_re === 1'b1 && !dmem_addr_ok(dmem_addr))
            fail_run("a load went outside the data memory model");
    end

    always @(negedge clk)
    begin
        if (i_dut.i_mips_cpu_checker.fail_count != 0)
            fail_run("an assertion in the bound checker failed");
    end

    initial
    begin
        wait (loaded);
        #((prog_words + tail_cycles) * wd_scale * clk_period);
        fail_run("watchdog expired before the program finished its stores");
    end

    initial
    begin
        clk         = 1'b0;
        rst         = 1'b1;
        wr_pending  = 1'b0;
        store_count = 0;
        loaded      = 1'b0;
        fill_dmem();
        load_input();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        @(negedge clk);
        check_addr("imem_addr", imem_addr, '0);   // first fetch
        while (store_count < record_total)
            @(posedge clk);
        repeat (tail_cycles) @(posedge clk);   // idle loop with no more stores
        if (i_dut.i_mips_cpu_checker.fail_count == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
            fail_run("an assertion in the bound checker failed");
    end

endmodule

//--- verif/program_input.txt
// program: word count (decimal), then one instruction word per line (hex)
// stores: record count (decimal), then address and data per line (hex), in order
31
20010005  // 00 addi $1, $0, 5
2002fffd  // 01 addi $2, $0, -3
00221820  // 02 add  $3, $1, $2
ac030000  // 03 sw   $3, 0($0)
00222022  // 04 sub  $4, $1, $2
3c051234  // 05 lui  $5, 0x1234
34a55678  // 06 ori  $5, $5, 0x5678
ac040004  // 07 sw   $4, 4($0)
ac050008  // 08 sw   $5, 8($0)
30a6ff0f  // 09 andi $6, $5, 0xff0f
00c13825  // 10 or   $7, $6, $1
ac07000c  // 11 sw   $7, 12($0)
00a76824  // 12 and  $13, $5, $7
ac0d0010  // 13 sw   $13, 16($0)
0041402a  // 14 slt  $8, $2, $1
0022482a  // 15 slt  $9, $1, $2
01285022  // 16 sub  $10, $9, $8
ac0a0014  // 17 sw   $10, 20($0)
8c0b0004  // 18 lw   $11, 4($0)
01636020  // 19 add  $12, $11, $3
ac0c0018  // 20 sw   $12, 24($0)
118b0003  // 21 beq  $12, $11, 3 (not taken)
ac0b001c  // 22 sw   $11, 28($0)
11a60002  // 23 beq  $13, $6, 2 (taken)
ac010020  // 24 sw   $1, 32($0) skipped
ac020020  // 25 sw   $2, 32($0) skipped
0800001d  // 26 j    29
ac030020  // 27 sw   $3, 32($0) skipped
ac040020  // 28 sw   $4, 32($0) skipped
ac080020  // 29 sw   $8, 32($0)
0800001e  // 30 j    30
9
00000000 00000002  // add
00000004 00000008  // sub
00000008 12345678  // lui then ori
0000000c 0000560d  // andi then or
00000010 00005608  // and
00000014 ffffffff  // slt, slt, sub
00000018 0000000a  // lw then add
0000001c 00000008  // after beq not taken
00000020 00000001  // after beq taken and j

//--- all.f
source/cpu_pkg.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/mips_cpu.sv
verif/mips_cpu_checker.sv
verif/tb_mips_cpu.sv

//--- Bender.yml
package:
  name: mips_cpu

sources:
  - source/cpu_pkg.sv
  - source/register_file.sv
  - source/fetch_stage.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/memory_stage.sv
  - source/hazard_unit.sv
  - source/mips_cpu.sv
  - target: simulation
    files:
      - verif/mips_cpu_checker.sv
      - verif/tb_mips_cpu.sv
